/* Makefile */
# Verilator build and run of the DMA response path testbench

VERILATOR ?= verilator
TOP       ?= dma_resp_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard verif/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf $(OBJ_DIR)

/* hw/bus_write_arbiter.sv */
// Write arbiter: drains the handlers onto one memory write port and merges their done events
`timescale 1ns/1ps
`default_nettype none

module bus_write_arbiter (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [dma_bus_pkg::N_CH-1:0] req_valid,
  input  dma_bus_pkg::wr_req_t         req [dma_bus_pkg::N_CH],
  input  logic [dma_bus_pkg::N_CH-1:0] req_last,
  output logic [dma_bus_pkg::N_CH-1:0] req_grant,
  input  logic [dma_bus_pkg::N_CH-1:0] done_req,
  input  dma_bus_pkg::done_t           done_info [dma_bus_pkg::N_CH],
  output logic [dma_bus_pkg::N_CH-1:0] done_ack,
  output logic                         wr_valid,
  output dma_bus_pkg::wr_req_t         wr_req,
  input  logic                         wr_ready,
  output logic                         done_valid,
  output dma_bus_pkg::done_t           done
);
  import dma_bus_pkg::*;

  ch_t     wr_ptr;
  ch_t     wr_sel;
  logic    wr_any;
  logic    locked;
  ch_t     lock_ch;
  ch_t     dn_ptr;
  ch_t     dn_sel;
  logic    dn_any;
  logic    q_push;
  logic    q_full;
  logic    q_empty;
  wr_req_t q_in;

  // First set bit after last, wrapping, with last itself lowest.
  // Relies on N_CH filling the ch_t range
  function automatic ch_t rr_pick(input logic [N_CH-1:0] mask, input ch_t last);
    ch_t pick;
    ch_t idx;
    pick = last;
    for (int i = N_CH; i >= 1; i--) begin
      idx = last + ch_t'(i);
      if (mask[idx]) begin
        pick = idx;
      end
    end
    return pick;
  endfunction

  ////////////////////
  // Write grant
  ////////////////////

  // A locked handler keeps the port until its last write
  assign wr_sel = locked ? lock_ch : rr_pick(req_valid, wr_ptr);
  assign wr_any = req_valid[wr_sel];
  assign q_push = wr_any && !q_full;
  assign q_in   = req[wr_sel];

  always_comb begin
    req_grant         = '0;
    req_grant[wr_sel] = q_push;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      locked  <= 1'b0;
      lock_ch <= '0;
      wr_ptr  <= ch_t'(N_CH - 1);
    end else if (q_push) begin
      lock_ch <= wr_sel;
      if (req_last[wr_sel]) begin
        locked <= 1'b0;
        wr_ptr <= wr_sel;
      end else begin
        locked <= 1'b1;
      end
    end
  end

  // Output queue decouples grants from memory stalls
  sync_fifo #(
    .T     (wr_req_t),
    .DEPTH (OUT_DEPTH)
  ) out_q (
    .clk       (clk),
    .rst       (rst),
    .push      (q_push),
    .push_data (q_in),
    .pop       (wr_valid && wr_ready),
    .pop_data  (wr_req),
    .empty     (q_empty),
    .full      (q_full)
  );

  assign wr_valid = !q_empty;

  ////////////////////
  // Done merge
  ////////////////////

  // Separate rotation, one acknowledge per cycle
  assign dn_sel = rr_pick(done_req, dn_ptr);
  assign dn_any = done_req[dn_sel];

  always_comb begin
    done_ack         = '0;
    done_ack[dn_sel] = dn_any;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dn_ptr     <= ch_t'(N_CH - 1);
      done_valid <= 1'b0;
    end else begin
      done_valid <= dn_any;
      if (dn_any) begin
        dn_ptr <= dn_sel;
      end
    end
  end

  // Event payload follows the pulse by no cycles
  always_ff @(posedge clk) begin
    done <= done_info[dn_sel];
  end

endmodule

`default_nettype wire

/* hw/dma_bus_pkg.sv */
// Local memory write port and done event types, imported by the handlers, arbiter and top
`default_nettype none

package dma_bus_pkg;

  // Number of response handlers, one per channel
  localparam int N_CH = 4;

  typedef logic [1:0] ch_t;
  // Transfer table pointer
  typedef logic [1:0] id_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } wr_req_t;

  typedef struct packed {
    ch_t channel;
    id_t id;
  } done_t;

  // Arbiter output queue in front of the memory port
  localparam int OUT_DEPTH = 2;

endpackage

`default_nettype wire

/* hw/dma_noc_pkg.sv */
// NoC flit and response packet layout, imported by the dispatcher, the handlers and the top
`default_nettype none

package dma_noc_pkg;

  // Flit is a 2-bit type tag above a 32-bit content word
  localparam int FLIT_W = 34;

  // Flit type encodings
  localparam logic [1:0] FLIT_PAYLOAD = 2'b00;
  localparam logic [1:0] FLIT_HEADER  = 2'b01;
  localparam logic [1:0] FLIT_LAST    = 2'b10;
  localparam logic [1:0] FLIT_SINGLE  = 2'b11;

  typedef struct packed {
    logic [1:0]        flit_type;
    logic [FLIT_W-3:0] content;
  } flit_t;

  // Header fields, overlaid on the content word of a header flit
  typedef struct packed {
    logic [3:0]         pkt_type;
    logic [1:0]         channel;
    logic [1:0]         id;
    logic               resp_last;
    logic [FLIT_W-12:0] rsvd;
  } hdr_t;

  // Only the two response types are handled, everything else is dropped
  localparam logic [3:0] PKT_L2R_RESP = 4'd2;
  localparam logic [3:0] PKT_R2L_RESP = 4'd3;

  // Buffer depths double as the initial credit counts upstream
  localparam int IN_DEPTH      = 4;
  localparam int HANDLER_DEPTH = 4;
  localparam int HANDLER_CNT_W = $clog2(HANDLER_DEPTH + 1);

endpackage

`default_nettype wire

/* hw/dma_resp_top.sv */
// Top of the DMA response path: NoC flits in, memory writes and done pulses out
`timescale 1ns/1ps
`default_nettype none

module dma_resp_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 noc_valid,
  input  dma_noc_pkg::flit_t   noc_flit,
  output logic                 noc_credit,
  output logic                 wr_valid,
  output dma_bus_pkg::wr_req_t wr_req,
  input  logic                 wr_ready,
  output logic                 done_valid,
  output dma_bus_pkg::done_t   done
);
  import dma_noc_pkg::*;
  import dma_bus_pkg::*;

  // Dispatcher to handlers
  logic [N_CH-1:0] h_valid;
  flit_t           h_flit [N_CH];
  logic [N_CH-1:0] h_credit;

  // Handlers to arbiter
  logic [N_CH-1:0] req_valid;
  wr_req_t         req [N_CH];
  logic [N_CH-1:0] req_last;
  logic [N_CH-1:0] req_grant;
  logic [N_CH-1:0] done_req;
  done_t           done_info [N_CH];
  logic [N_CH-1:0] done_ack;

  resp_dispatch resp_dispatch_i (
    .clk        (clk),
    .rst        (rst),
    .noc_valid  (noc_valid),
    .noc_flit   (noc_flit),
    .noc_credit (noc_credit),
    .h_valid    (h_valid),
    .h_flit     (h_flit),
    .h_credit   (h_credit)
  );

  // One handler per channel, each knowing its own channel number
  for (genvar k = 0; k < N_CH; k++) begin : g_handler
    resp_handler #(
      .CH (ch_t'(k))
    ) resp_handler_i (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (h_valid[k]),
      .in_flit   (h_flit[k]),
      .credit    (h_credit[k]),
      .req_valid (req_valid[k]),
      .req       (req[k]),
      .req_last  (req_last[k]),
      .req_grant (req_grant[k]),
      .done_req  (done_req[k]),
      .done_info (done_info[k]),
      .done_ack  (done_ack[k])
    );
  end

  bus_write_arbiter bus_write_arbiter_i (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .req_last   (req_last),
    .req_grant  (req_grant),
    .done_req   (done_req),
    .done_info  (done_info),
    .done_ack   (done_ack),
    .wr_valid   (wr_valid),
    .wr_req     (wr_req),
    .wr_ready   (wr_ready),
    .done_valid (done_valid),
    .done       (done)
  );

endmodule

`default_nettype wire

/* hw/resp_dispatch.sv */
// Response dispatcher: buffers NoC flits and steers each packet to its channel's handler
`timescale 1ns/1ps
`default_nettype none

module resp_dispatch (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             noc_valid,
  input  dma_noc_pkg::flit_t               noc_flit,
  output logic                             noc_credit,
  output logic [dma_bus_pkg::N_CH-1:0]     h_valid,
  output dma_noc_pkg::flit_t               h_flit [dma_bus_pkg::N_CH],
  input  logic [dma_bus_pkg::N_CH-1:0]     h_credit
);
  import dma_noc_pkg::*;
  import dma_bus_pkg::*;

  flit_t                    head;
  hdr_t                     hdr;
  logic                     empty;
  logic                     pop;
  logic                     is_end;
  logic                     locked;
  ch_t                      lock_ch;
  ch_t                      tgt;
  logic [HANDLER_CNT_W-1:0] h_cnt [N_CH];

  ////////////////////
  // Input buffer
  ////////////////////

  // Flits from the NoC port, one entry per source credit
  sync_fifo #(
    .T     (flit_t),
    .DEPTH (IN_DEPTH)
  ) in_buf (
    .clk       (clk),
    .rst       (rst),
    .push      (noc_valid),
    .push_data (noc_flit),
    .pop       (pop),
    .pop_data  (head),
    .empty     (empty),
    .full      ()
  );

  ////////////////////
  // Steering
  ////////////////////

  assign hdr    = hdr_t'(head.content);
  assign is_end = (head.flit_type == FLIT_LAST) || (head.flit_type == FLIT_SINGLE);

  // Outside a packet the head is a header and names the channel
  assign tgt = locked ? lock_ch : hdr.channel;

  // Forward only if the target handler has buffer room
  assign pop        = !empty && (h_cnt[tgt] != '0);
  // Credit back to the source in the cycle of the pop
  assign noc_credit = pop;

  always_comb begin
    for (int k = 0; k < N_CH; k++) begin
      h_valid[k] = pop && (tgt == ch_t'(k));
      h_flit[k]  = head;
    end
  end

  // Hold the channel until the end flit of the packet has passed
  always_ff @(posedge clk) begin
    if (rst) begin
      locked  <= 1'b0;
      lock_ch <= '0;
    end else if (pop) begin
      if (is_end) begin
        locked <= 1'b0;
      end else begin
        locked  <= 1'b1;
        lock_ch <= tgt;
      end
    end
  end

  ////////////////////
  // Handler credits
  ////////////////////

  // One counter per handler, spent on forward, refilled on the handler's pop
  always_ff @(posedge clk) begin
    for (int k = 0; k < N_CH; k++) begin
      if (rst) begin
        h_cnt[k] <= HANDLER_CNT_W'(HANDLER_DEPTH);
      end else begin
        h_cnt[k] <= h_cnt[k] - HANDLER_CNT_W'(h_valid[k]) + HANDLER_CNT_W'(h_credit[k]);
      end
    end
  end

endmodule

`default_nettype wire

/* hw/resp_handler.sv */
// Per-channel response handler: turns R2L data flits into memory writes and raises done events
`timescale 1ns/1ps
`default_nettype none

module resp_handler #(
  parameter dma_bus_pkg::ch_t CH = '0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  dma_noc_pkg::flit_t   in_flit,
  output logic                 credit,
  output logic                 req_valid,
  output dma_bus_pkg::wr_req_t req,
  output logic                 req_last,
  input  logic                 req_grant,
  output logic                 done_req,
  output dma_bus_pkg::done_t   done_info,
  input  logic                 done_ack
);
  import dma_noc_pkg::*;
  import dma_bus_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_GET_SIZE,
    ST_GET_ADDR,
    ST_DATA
  } state_t;

  state_t      state;
  state_t      nxt_state;
  flit_t       head;
  hdr_t        hdr;
  logic        empty;
  logic        pop;
  logic        end_flit;
  logic        set_done;
  logic [31:0] addr;
  id_t         resp_id;
  logic        resp_last;

  // Packet buffer, sized to the dispatcher's credit count
  sync_fifo #(
    .T     (flit_t),
    .DEPTH (HANDLER_DEPTH)
  ) pkt_buf (
    .clk       (clk),
    .rst       (rst),
    .push      (in_valid),
    .push_data (in_flit),
    .pop       (pop),
    .pop_data  (head),
    .empty     (empty),
    .full      ()
  );

  assign hdr      = hdr_t'(head.content);
  assign end_flit = (head.flit_type == FLIT_LAST) || (head.flit_type == FLIT_SINGLE);
  assign credit   = pop;

  // Write request comes straight from the buffer head
  assign req.addr  = addr;
  assign req.data  = head.content;
  assign req_last  = end_flit;
  assign done_info = '{channel: CH, id: resp_id};

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    nxt_state = state;
    pop       = 1'b0;
    set_done  = 1'b0;
    req_valid = 1'b0;
    case (state)
      ST_IDLE: begin
        // A pending done blocks the next header
        pop = !empty && !done_req;
        if (pop) begin
          if (hdr.pkt_type == PKT_L2R_RESP) begin
            set_done = 1'b1;
          end else if (hdr.pkt_type == PKT_R2L_RESP) begin
            nxt_state = ST_GET_SIZE;
          end
          // Unknown type is popped and dropped
        end
      end
      ST_GET_SIZE: begin
        // Size word is not used
        pop = !empty;
        if (pop) begin
          nxt_state = ST_GET_ADDR;
        end
      end
      ST_GET_ADDR: begin
        pop = !empty;
        if (pop) begin
          nxt_state = ST_DATA;
        end
      end
      ST_DATA: begin
        // Flit leaves the buffer only once its write is granted
        req_valid = !empty;
        pop       = req_valid && req_grant;
        if (pop && end_flit) begin
          nxt_state = ST_IDLE;
          set_done  = resp_last;
        end
      end
      default: begin
        nxt_state = ST_IDLE;
      end
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      done_req <= 1'b0;
    end else begin
      state <= nxt_state;
      if (set_done) begin
        done_req <= 1'b1;
      end else if (done_ack) begin
        done_req <= 1'b0;
      end
    end
  end

  // Transfer context of the current packet
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && pop) begin
      resp_id   <= hdr.id;
      resp_last <= hdr.resp_last;
    end
    if (state == ST_GET_ADDR && pop) begin
      addr <= head.content;
    end else if (state == ST_DATA && pop) begin
      // Word writes at consecutive addresses
      addr <= addr + 32'd4;
    end
  end

endmodule

`default_nettype wire

/* hw/sync_fifo.sv */
// Register-array FIFO with a type-parameter payload, instantiated for flits and write requests
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output T     pop_data,
  output logic empty,
  output logic full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  // One extra bit so a full FIFO can be told from an empty one
  logic [AW:0]   count;

  // Storage array
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at DEPTH, which need not be a power of two
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry is visible without a read cycle
  assign pop_data = mem[rd_ptr];
  assign empty    = (count == '0);
  assign full     = (count == (AW + 1)'(DEPTH));

endmodule

`default_nettype wire

/* src.f */
+incdir+verif
hw/dma_noc_pkg.sv
hw/dma_bus_pkg.sv
hw/sync_fifo.sv
hw/resp_dispatch.sv
hw/resp_handler.sv
hw/bus_write_arbiter.sv
hw/dma_resp_top.sv
verif/dma_resp_monitor.sv
verif/dma_resp_checker.sv
verif/dma_resp_tb.sv

/* verif/dma_resp_checker.sv */
// Credit range, write hold and grant exclusivity assertions, bound into dispatcher and arbiter
`timescale 1ns/1ps
`default_nettype none

module dma_resp_checker #(
  parameter int N          = 4,
  parameter int CNT_W      = 3,
  parameter int MAX_CNT    = 4,
  // Rule groups present at this bind site
  parameter bit CHK_CREDIT = 1'b1,
  parameter bit CHK_WRITE  = 1'b1
) (
  input logic                 clk,
  input logic                 rst,
  input logic [N*CNT_W-1:0]   cnt,
  input logic                 wr_valid,
  input logic                 wr_ready,
  input dma_bus_pkg::wr_req_t wr_req,
  input logic [N-1:0]         grant
);

  int cnt_fails   = 0;
  int hold_fails  = 0;
  int grant_fails = 0;
  int fail_cnt;

  assign fail_cnt = cnt_fails + hold_fails + grant_fails;

  // All counters packed side by side, channel 0 lowest
  function automatic logic cnt_in_range(input logic [N*CNT_W-1:0] v);
    logic ok;
    ok = 1'b1;
    for (int k = 0; k < N; k++) begin
      if (int'(v[k*CNT_W +: CNT_W]) > MAX_CNT) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  if (CHK_CREDIT) begin : g_credit
    credit_range: assert property (@(posedge clk) disable iff (rst) cnt_in_range(cnt))
      else begin
        cnt_fails = cnt_fails + 1;
        $error("handler credit counter above its buffer depth");
      end
  end

  if (CHK_WRITE) begin : g_write
    // Stalled write must not change
    write_hold: assert property (@(posedge clk) disable iff (rst)
      wr_valid && !wr_ready |=> $stable(wr_req))
      else begin
        hold_fails = hold_fails + 1;
        $error("write request changed while stalled");
      end

    grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
      else begin
        grant_fails = grant_fails + 1;
        $error("more than one write grant high");
      end
  end

endmodule

////////////////////
// Bindings
////////////////////

// Dispatcher side checks only the credit counters
bind resp_dispatch dma_resp_checker #(
  .N          (dma_bus_pkg::N_CH),
  .CNT_W      (dma_noc_pkg::HANDLER_CNT_W),
  .MAX_CNT    (dma_noc_pkg::HANDLER_DEPTH),
  .CHK_CREDIT (1'b1),
  .CHK_WRITE  (1'b0)
) disp_chk (
  .clk      (clk),
  .rst      (rst),
  .cnt      ({h_cnt[3], h_cnt[2], h_cnt[1], h_cnt[0]}),
  .wr_valid (1'b0),
  .wr_ready (1'b0),
  .wr_req   ('0),
  .grant    ('0)
);

// Arbiter side checks the memory port and the grants
bind bus_write_arbiter dma_resp_checker #(
  .N          (dma_bus_pkg::N_CH),
  .CNT_W      (dma_noc_pkg::HANDLER_CNT_W),
  .MAX_CNT    (dma_noc_pkg::HANDLER_DEPTH),
  .CHK_CREDIT (1'b0),
  .CHK_WRITE  (1'b1)
) arb_chk (
  .clk      (clk),
  .rst      (rst),
  .cnt      ('0),
  .wr_valid (wr_valid),
  .wr_ready (wr_ready),
  .wr_req   (wr_req),
  .grant    (req_grant)
);

`default_nettype wire

/* verif/dma_resp_tb.svh */
// Stimulus row layout and data pattern, included by the testbench and its monitor
`ifndef DMA_RESP_TB_SVH
`define DMA_RESP_TB_SVH

// Number of packets in the stimulus table
localparam int N_ROWS = 10;

// One response packet per row
// Test names are exactly eight characters
typedef struct packed {
  logic [63:0]      name;
  logic             l2r;
  dma_bus_pkg::ch_t ch;
  dma_bus_pkg::id_t id;
  logic             resp_last;
  logic [31:0]      addr;
  logic [7:0]       words;
} test_row_t;

// Data word w of the packet in row r, unique over the whole table
function automatic logic [31:0] payload_word(input int r, input int w);
  logic [31:0] word;
  word = 32'hd5a0_0000 ^ (32'(r) << 12) ^ (32'(w) * 32'h0000_0101);
  return word;
endfunction

`endif

/* verif/dma_resp_monitor.sv */
// Testbench monitor: compares memory writes and done pulses with expectations from the table
`timescale 1ns/1ps
`default_nettype none

`include "dma_resp_tb.svh"

module dma_resp_monitor (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wr_valid,
  input  dma_bus_pkg::wr_req_t wr_req,
  input  logic                 wr_ready,
  input  logic                 done_valid,
  input  dma_bus_pkg::done_t   done,
  input  test_row_t            rows [N_ROWS],
  input  logic                 at_end,
  output int                   val_errs,
  output int                   order_errs,
  output int                   miss_errs,
  output int                   extra_errs,
  output int                   pending,
  output logic                 reported
);
  import dma_bus_pkg::*;

  // One expected memory write
  typedef struct packed {
    logic [63:0] name;
    ch_t         ch;
    logic [31:0] addr;
    logic [31:0] data;
    logic        last;
  } exp_wr_t;

  exp_wr_t wr_q [$];
  // Rows still owing a done event
  int      dn_q [$];
  logic    built;
  // Packet currently on the memory port
  logic    open;
  ch_t     open_ch;

  ////////////////////
  // Expectations
  ////////////////////

  task automatic build_expected();
    exp_wr_t e;
    for (int r = 0; r < N_ROWS; r++) begin
      if (rows[r].l2r) begin
        dn_q.push_back(r);
      end else begin
        for (int w = 0; w < int'(rows[r].words); w++) begin
          e.name = rows[r].name;
          e.ch   = rows[r].ch;
          // Word writes at consecutive addresses
          e.addr = rows[r].addr + 32'(4 * w);
          e.data = payload_word(r, w);
          e.last = (w == int'(rows[r].words) - 1);
          wr_q.push_back(e);
        end
        // No done without resp_last
        if (rows[r].resp_last) begin
          dn_q.push_back(r);
        end
      end
    end
  endtask

  ////////////////////
  // Compare
  ////////////////////

  always @(posedge clk) begin : watch
    ch_t     ch;
    int      idx;
    exp_wr_t e;
    if (rst) begin
      val_errs   = 0;
      order_errs = 0;
      miss_errs  = 0;
      extra_errs = 0;
      built      = 1'b0;
      open       = 1'b0;
      open_ch    = '0;
      reported   = 1'b0;
    end else begin
      if (!built) begin
        build_expected();
        built = 1'b1;
      end
      if (wr_valid && wr_ready) begin
        // Table places channel k at addresses k*0x1000 and up
        ch  = wr_req.addr[13:12];
        idx = -1;
        for (int i = 0; i < wr_q.size(); i++) begin
          if (idx < 0 && wr_q[i].ch == ch) begin
            idx = i;
          end
        end
        if (open && ch != open_ch) begin
          $display("write for channel %0d arrived inside a packet of channel %0d", ch, open_ch);
          order_errs++;
        end
        if (idx < 0) begin
          $display("unexpected write to address %h with data %h", wr_req.addr, wr_req.data);
          extra_errs++;
          open = 1'b0;
        end else begin
          e = wr_q[idx];
          if (wr_req.addr !== e.addr || wr_req.data !== e.data) begin
            $display("error %s: expected %h/%h, actual %h/%h",
                     e.name, e.addr, e.data, wr_req.addr, wr_req.data);
            val_errs++;
          end
          wr_q.delete(idx);
          open    = !e.last;
          open_ch = ch;
        end
      end
      if (done_valid) begin
        // Done order across channels is free, so match by channel and id
        idx = -1;
        for (int i = 0; i < dn_q.size(); i++) begin
          if (idx < 0 && rows[dn_q[i]].ch == done.channel && rows[dn_q[i]].id == done.id) begin
            idx = i;
          end
        end
        if (idx < 0) begin
          $display("unexpected done event for channel %0d id %0d", done.channel, done.id);
          extra_errs++;
        end else begin
          dn_q.delete(idx);
        end
      end
      if (at_end && !reported) begin
        foreach (wr_q[i]) begin
          $display("missing write for %s at address %h", wr_q[i].name, wr_q[i].addr);
          miss_errs++;
        end
        foreach (dn_q[i]) begin
          $display("missing done event for %s", rows[dn_q[i]].name);
          miss_errs++;
        end
        reported = 1'b1;
      end
    end
    pending = wr_q.size() + dn_q.size();
  end

endmodule

`default_nettype wire

/* verif/dma_resp_tb.sv */
// Testbench top for the DMA response path, sends the packet table and prints the verdict
`timescale 1ns/1ps
`default_nettype none

`include "dma_resp_tb.svh"

module dma_resp_tb;
  import dma_noc_pkg::*;
  import dma_bus_pkg::*;

  // Percent of cycles with the memory stalling
  localparam int STALL_PCT = 30;

  logic      clk;
  logic      rst;
  logic      noc_valid;
  flit_t     noc_flit;
  logic      noc_credit;
  logic      wr_valid;
  wr_req_t   wr_req;
  logic      wr_ready;
  logic      done_valid;
  done_t     done;
  test_row_t rows [N_ROWS];
  logic      at_end;
  logic      reported;
  int        pending;
  int        val_errs;
  int        order_errs;
  int        miss_errs;
  int        extra_errs;
  int        assert_errs;
  int        credits;
  int        credit_errs = 0;
  int        cycles      = 0;
  int        limit       = 0;

  dma_resp_top dma_resp_top_i (
    .clk        (clk),
    .rst        (rst),
    .noc_valid  (noc_valid),
    .noc_flit   (noc_flit),
    .noc_credit (noc_credit),
    .wr_valid   (wr_valid),
    .wr_req     (wr_req),
    .wr_ready   (wr_ready),
    .done_valid (done_valid),
    .done       (done)
  );

  dma_resp_monitor resp_monitor (
    .clk        (clk),
    .rst        (rst),
    .wr_valid   (wr_valid),
    .wr_req     (wr_req),
    .wr_ready   (wr_ready),
    .done_valid (done_valid),
    .done       (done),
    .rows       (rows),
    .at_end     (at_end),
    .val_errs   (val_errs),
    .order_errs (order_errs),
    .miss_errs  (miss_errs),
    .extra_errs (extra_errs),
    .pending    (pending),
    .reported   (reported)
  );

  assign assert_errs = dma_resp_top_i.resp_dispatch_i.disp_chk.fail_cnt
                     + dma_resp_top_i.bus_write_arbiter_i.arb_chk.fail_cnt;

  ////////////////////
  // Clock, memory, timeout
  ////////////////////

  always #10 clk = ~clk;

  // Random memory stalls
  always @(posedge clk) begin
    #1;
    wr_ready = (int'($urandom_range(99)) >= STALL_PCT);
  end

  // Source credits, spent per flit sent and returned by noc_credit
  always @(posedge clk) begin : credit_track
    int nxt;
    nxt = credits + int'(noc_credit) - int'(noc_valid);
    if (rst) begin
      credits <= IN_DEPTH;
    end else begin
      if (nxt < 0 || nxt > IN_DEPTH) begin
        $display("source credit count left its range, now %0d", nxt);
        credit_errs++;
      end
      credits <= nxt;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles == limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("test failed");
      $finish;
    end
  end

  ////////////////////
  // Sender
  ////////////////////

  function automatic test_row_t make_row(input logic [63:0] name, input logic l2r,
                                         input int ch, input int id, input logic last,
                                         input logic [31:0] addr, input int words);
    test_row_t row;
    row.name      = name;
    row.l2r       = l2r;
    row.ch        = ch_t'(ch);
    row.id        = id_t'(id);
    row.resp_last = last;
    row.addr      = addr;
    row.words     = 8'(words);
    return row;
  endfunction

  // Waits for a credit, sends one flit, then idles a random gap
  task automatic send_flit(input flit_t f);
    int gap;
    while (credits <= 0) begin
      @(posedge clk);
      #1;
    end
    noc_valid = 1'b1;
    noc_flit  = f;
    @(posedge clk);
    #1;
    noc_valid = 1'b0;
    gap       = int'($urandom_range(2));
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Header, then size, address and data flits for an R2L response
  task automatic send_packet(input test_row_t row, input int r);
    hdr_t  hdr;
    flit_t f;
    hdr           = '0;
    hdr.pkt_type  = row.l2r ? PKT_L2R_RESP : PKT_R2L_RESP;
    hdr.channel   = row.ch;
    hdr.id        = row.id;
    hdr.resp_last = row.resp_last;
    f.flit_type   = row.l2r ? FLIT_SINGLE : FLIT_HEADER;
    f.content     = hdr;
    send_flit(f);
    if (!row.l2r) begin
      send_flit('{flit_type: FLIT_PAYLOAD, content: 32'(row.words)});
      send_flit('{flit_type: FLIT_PAYLOAD, content: row.addr});
      for (int w = 0; w < int'(row.words); w++) begin
        f.flit_type = (w == int'(row.words) - 1) ? FLIT_LAST : FLIT_PAYLOAD;
        f.content   = payload_word(r, w);
        send_flit(f);
      end
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int flits;
    int total;
    void'($urandom(37245));
    clk       = 1'b0;
    rst       = 1'b1;
    noc_valid = 1'b0;
    noc_flit  = '0;
    wr_ready  = 1'b0;
    at_end    = 1'b0;
    // Channel k lives at addresses k*0x1000 and up
    rows[0] = make_row("r2l_ch0a", 1'b0, 0, 1, 1'b1, 32'h0000_0100, 3);
    rows[1] = make_row("l2r_ch1a", 1'b1, 1, 2, 1'b1, 32'h0, 0);
    rows[2] = make_row("r2l_ch2a", 1'b0, 2, 0, 1'b1, 32'h0000_2040, 5);
    rows[3] = make_row("r2l_nodn", 1'b0, 3, 3, 1'b0, 32'h0000_3000, 2);
    rows[4] = make_row("r2l_one1", 1'b0, 1, 1, 1'b1, 32'h0000_1200, 1);
    // Back to back on different channels
    rows[5] = make_row("b2b_ch0b", 1'b0, 0, 2, 1'b1, 32'h0000_0200, 4);
    rows[6] = make_row("b2b_ch1b", 1'b0, 1, 3, 1'b1, 32'h0000_1300, 4);
    rows[7] = make_row("b2b_ch2b", 1'b0, 2, 1, 1'b1, 32'h0000_2300, 4);
    rows[8] = make_row("l2r_ch3b", 1'b1, 3, 0, 1'b1, 32'h0, 0);
    rows[9] = make_row("r2l_ch3c", 1'b0, 3, 2, 1'b1, 32'h0000_3100, 6);
    flits = 0;
    for (int i = 0; i < N_ROWS; i++) begin
      flits += rows[i].l2r ? 1 : 3 + int'(rows[i].words);
    end
    limit = 40 * flits + 200;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < N_ROWS; i++) begin
      send_packet(rows[i], i);
    end
    // All expected writes and done events seen
    while (pending != 0) begin
      @(posedge clk);
      #1;
    end
    // Quiet time to catch extra events
    repeat (20) @(posedge clk);
    #1;
    at_end = 1'b1;
    while (!reported) begin
      @(posedge clk);
      #1;
    end
    total = val_errs + order_errs + miss_errs + extra_errs + credit_errs + assert_errs;
    $display("errors: value %0d, order %0d, missing %0d, extra %0d, credit %0d, assertion %0d",
             val_errs, order_errs, miss_errs, extra_errs, credit_errs, assert_errs);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
